// File: design/csi2_apb_regs.sv
module csi2_apb_regs #(
  parameter int CNT_WIDTH = 16
)(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  rx_bus_pkg::apb_req_t   apb_i,
  output rx_bus_pkg::apb_rsp_t   apb_o,
  input  rx_bus_pkg::ecc_evt_t   ecc_evt_i,
  input  rx_bus_pkg::frame_evt_t frame_evt_i,
  output logic                   enable_o
);

  logic                   access;
  logic                   addr_err;
  logic                   wr_en;
  logic [31:0]            rdata;
  logic [CNT_WIDTH - 1:0] cor_q;
  logic [CNT_WIDTH - 1:0] unc_q;
  logic [CNT_WIDTH - 1:0] line_run_q;    // lines of the frame in flight
  logic [CNT_WIDTH - 1:0] lines_q;
  logic [15:0]            frame_q;

  assign access   = apb_i.psel && apb_i.penable;
  assign addr_err = apb_i.paddr > 4'hC;
  assign wr_en    = access && apb_i.pwrite && !addr_err;

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_o   <= 1'b0;
      cor_q      <= '0;
      unc_q      <= '0;
      line_run_q <= '0;
      lines_q    <= '0;
      frame_q    <= '0;
    end else begin
      if (wr_en && apb_i.paddr[3:2] == 2'd0) enable_o <= apb_i.pwdata[0];
      if (wr_en && apb_i.paddr[3:2] == 2'd1) begin // any write clears
        cor_q <= '0;
        unc_q <= '0;
      end else begin
        if (ecc_evt_i.corrected && cor_q != '1) cor_q <= cor_q + 1'b1;
        if (ecc_evt_i.uncorrectable && unc_q != '1) unc_q <= unc_q + 1'b1;
      end
      if (frame_evt_i.frame_start) begin
        frame_q    <= frame_evt_i.frame_num;
        line_run_q <= '0;
      end else if (frame_evt_i.line_done && line_run_q != '1) begin
        line_run_q <= line_run_q + 1'b1;
      end
      if (frame_evt_i.frame_end) lines_q <= line_run_q;
    end
  end

  always_comb begin
    case (apb_i.paddr[3:2])
      2'd0:    rdata = {31'd0, enable_o};
      2'd1:    rdata = {16'(unc_q), 16'(cor_q)};
      2'd2:    rdata = {16'd0, frame_q};
      default: rdata = 32'(lines_q);
    endcase
  end

  assign apb_o = '{prdata: rdata, pready: 1'b1, pslverr: access && addr_err};

endmodule

// File: design/csi2_hdr_ecc.sv
module csi2_hdr_ecc (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  rx_bus_pkg::word_stream_t in_i,
  output logic                     in_ready_o,
  input  logic                     hdr_expect_i,
  output rx_bus_pkg::hdr_word_t    out_o,
  input  logic                     out_ready_i,
  output rx_bus_pkg::ecc_evt_t     evt_o
);

  // parity membership of data bits 0..23, bit k set when the bit feeds P[k]
  localparam logic [5:0] COL [24] = '{
    6'h07, 6'h0B, 6'h0D, 6'h0E, 6'h13, 6'h15, 6'h16, 6'h19,
    6'h1A, 6'h1C, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2A, 6'h2C,
    6'h31, 6'h32, 6'h34, 6'h38, 6'h1F, 6'h2F, 6'h37, 6'h3B
  };

  logic        load;
  logic [5:0]  calc;
  logic [5:0]  syn;
  logic [31:0] fixed;
  logic        hit;
  logic        valid_q;
  logic [31:0] data_q;
  logic        is_hdr_q;
  logic        bad_q;
  logic        cor_q;
  logic        unc_q;

  assign in_ready_o = !valid_q || out_ready_i; // slice empty or drained
  assign load       = in_i.tvalid && in_ready_o;

  always_comb begin
    calc = '0;
    for (int i = 0; i < 24; i++) begin
      if (in_i.tdata[i]) calc ^= COL[i];
    end
    syn   = calc ^ in_i.tdata[29:24];
    fixed = in_i.tdata;
    hit   = 1'b0;
    for (int i = 0; i < 24; i++) begin
      if (syn == COL[i]) begin
        fixed[i] = ~fixed[i];
        hit      = 1'b1;
      end
    end
    // single set bit points at the ecc field itself
    for (int k = 0; k < 6; k++) begin
      if (syn == 6'(1 << k)) begin
        fixed[24 + k] = ~fixed[24 + k];
        hit           = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      cor_q   <= 1'b0;
      unc_q   <= 1'b0;
    end else begin
      if (load) valid_q <= 1'b1;
      else if (out_ready_i) valid_q <= 1'b0;
      cor_q <= load && hdr_expect_i && hit;
      unc_q <= load && hdr_expect_i && (syn != '0) && !hit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q   <= hdr_expect_i ? fixed : in_i.tdata;
      is_hdr_q <= hdr_expect_i;
      bad_q    <= hdr_expect_i && (syn != '0) && !hit;
    end
  end

  assign out_o = '{word: '{tdata: data_q, tvalid: valid_q}, is_hdr: is_hdr_q, bad: bad_q};
  assign evt_o = '{corrected: cor_q, uncorrectable: unc_q};

endmodule

// File: design/csi2_pkg.sv
package csi2_pkg;

  //////////////////////////////////////////////////
  // packet header
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [1:0] vc;                  // virtual channel
    logic [5:0] dt;                  // data type
  } di_t;

  // one header word, read as a long or a short packet depending on dt
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [7:0]  ecc;
      logic [15:0] wc;               // payload bytes
      di_t         di;
    } lpkt;
    struct packed {
      logic [7:0]  ecc;
      logic [15:0] frame_num;
      di_t         di;
    } spkt;
  } csi2_hdr_u;

  localparam logic [5:0] DT_FRAME_START = 6'h00;
  localparam logic [5:0] DT_FRAME_END   = 6'h01;
  localparam logic [5:0] DT_RAW10       = 6'h2B;

  //////////////////////////////////////////////////
  // RAW10 payload
  //////////////////////////////////////////////////

  // four pixels in five bytes, byte 0 in the low bits
  typedef struct packed {
    logic [7:0]      lsb;            // pixel n bits 1:0 at 2n+1:2n
    logic [3:0][7:0] msb;            // pixel n bits 9:2
  } raw10_grp_t;

endpackage

// File: design/csi2_pkt_fsm.sv
module csi2_pkt_fsm (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     enable_i,
  input  rx_bus_pkg::hdr_word_t    in_i,
  output logic                     in_ready_o,
  output logic                     hdr_expect_o,
  output rx_bus_pkg::word_stream_t out_o,
  output logic                     out_last_o,
  input  logic                     out_ready_i,
  output logic                     cnt_load_o,
  output logic [15:0]              cnt_wc_o,
  output logic                     cnt_en_o,
  input  logic                     last_word_i,
  output rx_bus_pkg::frame_evt_t   evt_o
);
  import csi2_pkg::*;

  typedef enum logic [1:0] {ST_HDR, ST_PAYLOAD, ST_DROP, ST_FOOTER} state_e;

  state_e    state_q;
  state_e    state_d;
  csi2_hdr_u hdr;
  logic      take;
  logic      in_hdr;
  logic      is_long;
  logic      good_vc0;
  logic      in_body;

  assign hdr.raw    = in_i.word.tdata;
  assign is_long    = hdr.lpkt.di.dt >= 6'h10;
  assign good_vc0   = !in_i.bad && (hdr.lpkt.di.vc == 2'd0);
  assign in_ready_o = !(enable_i && state_q == ST_PAYLOAD) || out_ready_i; // sink when off
  assign take       = in_i.word.tvalid && in_ready_o;
  assign in_hdr     = take && enable_i && state_q == ST_HDR && in_i.is_hdr;
  assign in_body    = take && enable_i && (state_q == ST_PAYLOAD || state_q == ST_DROP);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_HDR: begin
        // a bad short header, or a word that failed as a header, is skipped alone
        if (in_i.is_hdr && is_long) begin
          if (hdr.lpkt.wc == '0) state_d = ST_FOOTER;
          else if (good_vc0 && hdr.lpkt.di.dt == DT_RAW10) state_d = ST_PAYLOAD;
          else state_d = ST_DROP;
        end
      end
      ST_PAYLOAD, ST_DROP: if (last_word_i) state_d = ST_FOOTER;
      default: state_d = ST_HDR;
    endcase
    if (!enable_i) state_d = ST_HDR;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) state_q <= ST_HDR;
    else if (take || !enable_i) state_q <= state_d;
  end

  // the word entering the ECC stage follows the one held in front of us
  assign hdr_expect_o = enable_i &&
                        (in_i.word.tvalid ? state_d == ST_HDR : state_q == ST_HDR);

  assign out_o      = '{tdata: in_i.word.tdata,
                        tvalid: enable_i && state_q == ST_PAYLOAD && in_i.word.tvalid};
  assign out_last_o = state_q == ST_PAYLOAD && last_word_i;

  assign cnt_wc_o   = hdr.lpkt.wc;
  assign cnt_load_o = in_hdr && is_long && hdr.lpkt.wc != '0;
  assign cnt_en_o   = in_body;

  assign evt_o = '{
    frame_start: in_hdr && !is_long && good_vc0 && hdr.spkt.di.dt == DT_FRAME_START,
    frame_end:   in_hdr && !is_long && good_vc0 && hdr.spkt.di.dt == DT_FRAME_END,
    frame_num:   hdr.spkt.frame_num,
    line_done:   in_body && state_q == ST_PAYLOAD && last_word_i
  };

endmodule

// File: design/csi2_px_serializer.sv
module csi2_px_serializer (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  rx_bus_pkg::grp_stream_t in_i,
  output logic                    in_ready_o,
  output rx_bus_pkg::pix_stream_t video_o,
  input  logic                    video_ready_i
);
  import csi2_pkg::*;

  raw10_grp_t grp_q;
  logic       user_q;
  logic       last_q;
  logic       full_q;
  logic [1:0] idx_q;                     // pixel being shown
  logic       step;
  logic       take;

  assign step       = full_q && video_ready_i;
  assign in_ready_o = !full_q || (step && idx_q == 2'd3);
  assign take       = in_i.tvalid && in_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
      idx_q  <= '0;
    end else if (take) begin
      full_q <= 1'b1;
      idx_q  <= '0;
    end else if (step) begin
      full_q <= idx_q != 2'd3;
      idx_q  <= idx_q + 2'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      grp_q  <= in_i.tdata;
      user_q <= in_i.tuser;
      last_q <= in_i.tlast;
    end
  end

  assign video_o = '{
    tdata:  {grp_q.msb[idx_q], grp_q.lsb[idx_q * 2 +: 2]},
    tuser:  user_q && idx_q == 2'd0,
    tlast:  last_q && idx_q == 2'd3,
    tvalid: full_q
  };

endmodule

// File: design/csi2_raw10_gbx.sv
module csi2_raw10_gbx (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  rx_bus_pkg::word_stream_t in_i,
  input  logic                     in_last_i,
  input  logic                     frame_start_i,
  output logic                     in_ready_o,
  output rx_bus_pkg::grp_stream_t  out_o,
  input  logic                     out_ready_i
);
  import csi2_pkg::*;

  logic [63:0] buf_q;
  logic [63:0] buf_d;
  logic [3:0]  cnt_q;                    // bytes held, 0..8
  logic [3:0]  cnt_d;
  logic [3:0]  cnt_mid;
  logic        grp_valid;
  logic        push;
  logic        pop;
  logic        line_end_q;               // buffer ends on a line boundary
  logic        sof_pend_q;               // frame start seen, no payload yet
  logic        sof_grp_q;                // bottom group opens the frame

  assign grp_valid  = cnt_q >= 4'd5;
  assign pop        = grp_valid && out_ready_i;
  assign in_ready_o = cnt_q <= 4'd4 || pop;
  assign push       = in_i.tvalid && in_ready_o;

  //////////////////////////////////////////////////
  // residue buffer, little endian
  //////////////////////////////////////////////////

  always_comb begin
    cnt_mid = pop ? cnt_q - 4'd5 : cnt_q;
    buf_d   = pop ? buf_q >> 40 : buf_q;
    cnt_d   = cnt_mid;
    if (push) begin
      buf_d[cnt_mid * 8 +: 32] = in_i.tdata;
      cnt_d = cnt_mid + 4'd4;
    end
  end

  always_ff @(posedge clk_i) begin
    buf_q <= buf_d;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q      <= '0;
      line_end_q <= 1'b0;
      sof_pend_q <= 1'b0;
      sof_grp_q  <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      if (push) line_end_q <= in_last_i;
      if (frame_start_i) sof_pend_q <= 1'b1;
      else if (push) sof_pend_q <= 1'b0;
      if (push && sof_pend_q) sof_grp_q <= 1'b1; // lines start group aligned
      else if (pop) sof_grp_q <= 1'b0;
    end
  end

  assign out_o = '{
    tdata:  raw10_grp_t'(buf_q[39:0]),
    tuser:  sof_grp_q,
    tlast:  line_end_q && cnt_q == 4'd5,
    tvalid: grp_valid
  };

endmodule

// File: design/csi2_rx_top.sv
module csi2_rx_top #(
  parameter int CNT_WIDTH = 16
)(
  input  logic                     px_clk_i,
  input  logic                     rst_n_i,
  input  rx_bus_pkg::word_stream_t pkt_i,
  output logic                     pkt_ready_o,
  output rx_bus_pkg::pix_stream_t  video_o,
  input  logic                     video_ready_i,
  input  rx_bus_pkg::apb_req_t     apb_i,
  output rx_bus_pkg::apb_rsp_t     apb_o
);
  import rx_bus_pkg::*;

  hdr_word_t    ecc_word;
  ecc_evt_t     ecc_evt;
  frame_evt_t   frame_evt;
  word_stream_t pay_word;
  grp_stream_t  grp;
  logic         hdr_expect;
  logic         fsm_ready;
  logic         pay_last;
  logic         gbx_ready;
  logic         ser_ready;
  logic         cnt_load;
  logic [15:0]  cnt_wc;
  logic         cnt_en;
  logic         last_word;
  logic         enable;

  csi2_hdr_ecc hdr_ecc (
    .clk_i        ( px_clk_i    ),
    .rst_n_i      ( rst_n_i     ),
    .in_i         ( pkt_i       ),
    .in_ready_o   ( pkt_ready_o ),
    .hdr_expect_i ( hdr_expect  ),
    .out_o        ( ecc_word    ),
    .out_ready_i  ( fsm_ready   ),
    .evt_o        ( ecc_evt     )
  );

  csi2_pkt_fsm pkt_fsm (
    .clk_i        ( px_clk_i   ),
    .rst_n_i      ( rst_n_i    ),
    .enable_i     ( enable     ),
    .in_i         ( ecc_word   ),
    .in_ready_o   ( fsm_ready  ),
    .hdr_expect_o ( hdr_expect ),
    .out_o        ( pay_word   ),
    .out_last_o   ( pay_last   ),
    .out_ready_i  ( gbx_ready  ),
    .cnt_load_o   ( cnt_load   ),
    .cnt_wc_o     ( cnt_wc     ),
    .cnt_en_o     ( cnt_en     ),
    .last_word_i  ( last_word  ),
    .evt_o        ( frame_evt  )
  );

  csi2_word_counter word_cnt (
    .clk_i       ( px_clk_i  ),
    .rst_n_i     ( rst_n_i   ),
    .load_i      ( cnt_load  ),
    .wc_i        ( cnt_wc    ),
    .en_i        ( cnt_en    ),
    .last_word_o ( last_word )
  );

  csi2_raw10_gbx gbx (
    .clk_i         ( px_clk_i              ),
    .rst_n_i       ( rst_n_i               ),
    .in_i          ( pay_word              ),
    .in_last_i     ( pay_last              ),
    .frame_start_i ( frame_evt.frame_start ),
    .in_ready_o    ( gbx_ready             ),
    .out_o         ( grp                   ),
    .out_ready_i   ( ser_ready             )
  );

  csi2_px_serializer px_ser (
    .clk_i         ( px_clk_i      ),
    .rst_n_i       ( rst_n_i       ),
    .in_i          ( grp           ),
    .in_ready_o    ( ser_ready     ),
    .video_o       ( video_o       ),
    .video_ready_i ( video_ready_i )
  );

  csi2_apb_regs #(
    .CNT_WIDTH   ( CNT_WIDTH )
  ) regs (
    .clk_i       ( px_clk_i  ),
    .rst_n_i     ( rst_n_i   ),
    .apb_i       ( apb_i     ),
    .apb_o       ( apb_o     ),
    .ecc_evt_i   ( ecc_evt   ),
    .frame_evt_i ( frame_evt ),
    .enable_o    ( enable    )
  );

endmodule

// File: design/csi2_word_counter.sv
module csi2_word_counter (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        load_i,
  input  logic [15:0] wc_i,
  input  logic        en_i,
  output logic        last_word_o
);

  logic [15:0] left_q;                   // payload bytes still to come

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      left_q <= '0;
    end else if (load_i) begin
      left_q <= wc_i;
    end else if (en_i) begin
      left_q <= (left_q > 16'd4) ? left_q - 16'd4 : '0;
    end
  end

  assign last_word_o = left_q <= 16'd4;

endmodule

// File: design/rx_bus_pkg.sv
package rx_bus_pkg;

  //////////////////////////////////////////////////
  // streams
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [31:0] tdata;
    logic        tvalid;
  } word_stream_t;

  typedef struct packed {
    word_stream_t word;
    logic         is_hdr;            // word was checked as a header
    logic         bad;               // uncorrectable header
  } hdr_word_t;

  typedef struct packed {
    csi2_pkg::raw10_grp_t tdata;
    logic                 tuser;     // first group of a frame
    logic                 tlast;     // last group of a line
    logic                 tvalid;
  } grp_stream_t;

  typedef struct packed {
    logic [9:0] tdata;
    logic       tuser;
    logic       tlast;
    logic       tvalid;
  } pix_stream_t;

  //////////////////////////////////////////////////
  // APB and event pulses
  //////////////////////////////////////////////////

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic        frame_start;
    logic        frame_end;
    logic [15:0] frame_num;
    logic        line_done;
  } frame_evt_t;

  typedef struct packed {
    logic corrected;
    logic uncorrectable;
  } ecc_evt_t;

endpackage

// File: list.f
+incdir+sim
design/csi2_pkg.sv
design/rx_bus_pkg.sv
design/csi2_hdr_ecc.sv
design/csi2_pkt_fsm.sv
design/csi2_word_counter.sv
design/csi2_raw10_gbx.sv
design/csi2_px_serializer.sv
design/csi2_apb_regs.sv
design/csi2_rx_top.sv
sim/csi2_rx_tb.sv

// File: sim/csi2_rx_checks.svh
//////////////////////////////////////////////////
// header ECC model
//////////////////////////////////////////////////

// CSI-2 parity equations, one mask of data bits 23:0 per parity bit
localparam logic [23:0] PARITY_MASK [6] = '{
  24'hF12CB7, 24'hF2555B, 24'h749A6D, 24'hB8E38E, 24'hDF03F0, 24'hEFFC00
};

function automatic logic [31:0] make_hdr(input logic [5:0] dt, input logic [15:0] field);
  logic [23:0] data;
  logic [5:0]  par;
  data = {field, 2'b00, dt};              // vc 0
  for (int k = 0; k < 6; k++) begin
    par[k] = ^(data & PARITY_MASK[k]);
  end
  return {2'b00, par, data};
endfunction

//////////////////////////////////////////////////
// RAW10 model
//////////////////////////////////////////////////

// bytes of line_q in stream order, five bytes give four pixels
task automatic add_line_pixels(input logic sof);
  logic [7:0]  bytes [$];
  logic [7:0]  lo;
  pix_stream_t px;
  int          n_grp;
  foreach (line_q[i]) begin
    for (int k = 0; k < 4; k++) begin
      bytes.push_back(line_q[i][8 * k +: 8]);
    end
  end
  n_grp = bytes.size() / 5;
  for (int g = 0; g < n_grp; g++) begin
    lo = bytes[5 * g + 4];
    for (int p = 0; p < 4; p++) begin
      px.tdata  = {bytes[5 * g + p], lo[2 * p +: 2]};
      px.tuser  = sof && g == 0 && p == 0;
      px.tlast  = g == n_grp - 1 && p == 3;
      px.tvalid = 1'b1;
      exp_q.push_back(px);
    end
  end
endtask

//////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////

task automatic check_pix(input string name, input int idx,
                         input pix_stream_t exp, input pix_stream_t act);
  checks++;
  if (exp.tdata !== act.tdata || exp.tuser !== act.tuser || exp.tlast !== act.tlast) begin
    errors++;
    $display("ERROR %s pixel %0d: expected data %h user %b last %b, actual data %h user %b last %b",
             name, idx, exp.tdata, exp.tuser, exp.tlast,
             act.tdata, act.tuser, act.tlast);
  end
endtask

task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
  checks++;
  if (exp !== act) begin
    errors++;
    $display("ERROR %s: expected %h, actual %h", name, exp, act);
  end
endtask

// File: sim/csi2_rx_tb.sv
module csi2_rx_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import rx_bus_pkg::*;

  localparam logic [5:0] DT_FS    = 6'h00;
  localparam logic [5:0] DT_FE    = 6'h01;
  localparam logic [5:0] DT_RAW10 = 6'h2B;
  localparam int N_TESTS    = 5;
  localparam int WAIT_LIMIT = 200;      // cycles without progress
  localparam int IDLE_WATCH = 300;      // window for the disabled frame

  typedef struct packed {
    logic [15:0] frame_num;
    logic [3:0]  lines;
    logic [15:0] wc;
    logic [31:0] err_mask;              // flipped bits of the first line header
    logic        stall;                 // random video_ready
    logic        enable;
  } test_row_t;

  logic         clk;
  logic         rst_n;
  word_stream_t pkt;
  logic         pkt_ready;
  pix_stream_t  video;
  logic         video_ready;
  apb_req_t     apb_req;
  apb_rsp_t     apb_rsp;

  test_row_t    rows [N_TESTS];
  string        names [N_TESTS];
  logic [31:0]  tx_q [$];
  logic [31:0]  line_q [$];
  pix_stream_t  exp_q [$];
  pix_stream_t  got_q [$];
  int           seed = 69;
  int           checks;
  int           errors;
  logic         stall_mode;
  logic [15:0]  last_frame;
  int           last_lines;

  csi2_rx_top #(
    .CNT_WIDTH     ( 16 )
  ) DUT (
    .px_clk_i      ( clk         ),
    .rst_n_i       ( rst_n       ),
    .pkt_i         ( pkt         ),
    .pkt_ready_o   ( pkt_ready   ),
    .video_o       ( video       ),
    .video_ready_i ( video_ready ),
    .apb_i         ( apb_req     ),
    .apb_o         ( apb_rsp     )
  );

  `include "csi2_rx_checks.svh"

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    int rnd;
    video_ready = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      if (stall_mode) begin
        rnd = $random(seed);
        video_ready = rnd[0];
      end else begin
        video_ready = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // drivers and monitors
  //////////////////////////////////////////////////

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Test failed");
    $finish;
  endtask

  task automatic apb_access(input logic write, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
    int waited;
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    waited = 0;
    @(negedge clk);
    while (!apb_rsp.pready) begin
      waited++;
      if (waited > WAIT_LIMIT) abort_run("APB access never saw pready");
      @(negedge clk);
    end
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    check_reg($sformatf("APB %h wait states", addr), 32'h0, 32'(waited));
    @(posedge clk);
    #1;
    apb_req = '0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] wdata);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b1, addr, wdata, rd, err);
    check_reg($sformatf("APB write %h pslverr", addr), 32'h0, {31'd0, err});
  endtask

  task automatic read_check(input string name, input logic [3:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b0, addr, '0, rd, err);
    check_reg(name, exp, rd);
    check_reg({name, " pslverr"}, 32'h0, {31'd0, err});
  endtask

  task automatic send_words(input string name);
    int waited;
    foreach (tx_q[i]) begin
      pkt = '{tdata: tx_q[i], tvalid: 1'b1};
      waited = 0;
      @(negedge clk);
      while (!pkt_ready) begin
        waited++;
        if (waited > WAIT_LIMIT) abort_run($sformatf("%s: pkt_ready_o stuck low", name));
        @(negedge clk);
      end
      @(posedge clk);
      #1;
    end
    pkt = '{tdata: '0, tvalid: 1'b0};
  endtask

  task automatic collect_pixels(input string name, input int n);
    int idle;
    got_q.delete();
    idle = 0;
    while (got_q.size() < n) begin
      @(negedge clk);
      if (video.tvalid && video_ready) begin
        got_q.push_back(video);
        idle = 0;
      end else begin
        idle++;
        if (idle > WAIT_LIMIT) abort_run($sformatf("%s: pixel stream stopped early", name));
      end
    end
  endtask

  task automatic count_beats(input int cycles, output int beats);
    beats = 0;
    for (int c = 0; c < cycles; c++) begin
      @(negedge clk);
      if (video.tvalid) beats++;
    end
  endtask

  //////////////////////////////////////////////////
  // frame builder and test sequence
  //////////////////////////////////////////////////

  task automatic build_frame(input test_row_t row);
    logic [31:0] hdr;
    logic [31:0] w;
    logic        dropped;
    logic        sof;
    tx_q.delete();
    exp_q.delete();
    sof = 1'b1;
    tx_q.push_back(make_hdr(DT_FS, row.frame_num));
    for (int l = 0; l < row.lines; l++) begin
      hdr     = make_hdr(DT_RAW10, row.wc);
      dropped = 1'b0;
      if (l == 0) begin
        hdr     ^= row.err_mask;
        dropped = $countones(row.err_mask) > 1;
      end
      tx_q.push_back(hdr);
      line_q.delete();
      for (int i = 0; i < row.wc / 4; i++) begin
        w = $random(seed);
        line_q.push_back(w);
        tx_q.push_back(w);
      end
      tx_q.push_back($random(seed)); // footer with an unchecked crc
      if (!dropped && row.enable) begin
        add_line_pixels(sof);
        sof = 1'b0;
      end
    end
    tx_q.push_back(make_hdr(DT_FE, row.frame_num));
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("%-16s %s, %0d errors", name, errors == err_before ? "ok" : "FAIL",
             errors - err_before);
  endtask

  task automatic check_apb_reset();
    logic [31:0] rd;
    logic        err;
    int          err_before;
    err_before = errors;
    check_reg("apb_reset pkt_ready", 32'h1, {31'd0, pkt_ready});
    check_reg("apb_reset video tvalid", 32'h0, {31'd0, video.tvalid});
    read_check("apb_reset CTRL", 4'h0, 32'h0);
    read_check("apb_reset ERR", 4'h4, 32'h0);
    read_check("apb_reset FRAME", 4'h8, 32'h0);
    read_check("apb_reset LINES", 4'hC, 32'h0);
    apb_write(4'h0, 32'h1);
    read_check("apb_reset CTRL", 4'h0, 32'h1);
    apb_access(1'b0, 4'hE, '0, rd, err); // past the register map
    check_reg("apb_reset pslverr", 32'h1, {31'd0, err});
    report_test("apb_reset", err_before);
  endtask

  task automatic run_test(input int idx);
    test_row_t row;
    string     name;
    int        err_before;
    int        beats;
    int        n_cor;
    int        n_unc;
    row        = rows[idx];
    name       = names[idx];
    err_before = errors;
    apb_write(4'h0, {31'd0, row.enable});
    apb_write(4'h4, 32'h0);             // clear both ecc counts
    build_frame(row);
    @(negedge clk);
    stall_mode = row.stall;
    @(posedge clk);
    #1;
    if (row.enable) begin
      fork
        send_words(name);
        collect_pixels(name, exp_q.size());
      join
      count_beats(16, beats);           // nothing may follow the last pixel
    end else begin
      fork
        send_words(name);
        count_beats(IDLE_WATCH, beats);
      join
    end
    stall_mode = 1'b0;
    @(posedge clk);
    #1;
    check_reg($sformatf("%s extra beats", name), 32'h0, 32'(beats));
    foreach (exp_q[i]) check_pix(name, i, exp_q[i], got_q[i]);
    n_cor = (row.enable && $countones(row.err_mask) == 1) ? 1 : 0;
    n_unc = (row.enable && $countones(row.err_mask) > 1) ? 1 : 0;
    if (row.enable) begin
      last_frame = row.frame_num;
      last_lines = row.lines - n_unc;
    end
    read_check({name, " ERR"}, 4'h4, {16'(n_unc), 16'(n_cor)});
    read_check({name, " FRAME"}, 4'h8, {16'd0, last_frame});
    read_check({name, " LINES"}, 4'hC, 32'(last_lines));
    got_q.delete();
    report_test(name, err_before);
  endtask

  initial begin
    rst_n      = 1'b0;
    pkt        = '0;
    apb_req    = '0;
    stall_mode = 1'b0;
    checks     = 0;
    errors     = 0;
    last_frame = '0;
    last_lines = 0;

    rows[0]  = '{frame_num: 16'h0011, lines: 4'd2, wc: 16'd40, err_mask: 32'h0000_0000,
                 stall: 1'b0, enable: 1'b1};
    names[0] = "clean_frame";
    rows[1]  = '{frame_num: 16'h0012, lines: 4'd2, wc: 16'd40, err_mask: 32'h0000_0100,
                 stall: 1'b0, enable: 1'b1};
    names[1] = "single_bit_hdr";
    rows[2]  = '{frame_num: 16'h0013, lines: 4'd2, wc: 16'd40, err_mask: 32'h0300_0000,
                 stall: 1'b0, enable: 1'b1};
    names[2] = "double_bit_hdr";
    rows[3]  = '{frame_num: 16'h0014, lines: 4'd2, wc: 16'd40, err_mask: 32'h0000_0000,
                 stall: 1'b1, enable: 1'b1};
    names[3] = "random_stall";
    rows[4]  = '{frame_num: 16'h0015, lines: 4'd2, wc: 16'd40, err_mask: 32'h0000_0000,
                 stall: 1'b0, enable: 1'b0};
    names[4] = "disabled";

    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    check_apb_reset();
    for (int t = 0; t < N_TESTS; t++) begin
      run_test(t);
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
